/* tb.f */
+incdir+verilog
+incdir+verif
verilog/imu_spi_pkg.sv
verilog/imu_sample_capture.sv
verilog/spi_packet_tx.sv
verilog/imu_spi_top.sv
verif/imu_spi_tb.sv

/* verif/imu_spi_tb_tasks.svh */
`ifndef IMU_SPI_TB_TASKS_SVH
`define IMU_SPI_TB_TASKS_SVH

// ------------------------------
// Random numbers
// ------------------------------

// 32-bit xorshift step with shifts 13, 17 and 5
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// ------------------------------
// Checking
// ------------------------------

// Four-state compare, so a floating sdo is caught as well as a wrong value
task automatic check_value(
    input string       name,
    input logic [31:0] actual,
    input logic [31:0] expected
);
    if (actual !== expected) begin
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
        $display("Simulation FAILED");
        $fatal(1, "mismatch on %s", name);
    end
endtask

// MISO must float whenever this slave is not selected
task automatic expect_sdo_released(input string when_text);
    check_value({"sdo ", when_text}, {31'b0, sdo}, {31'b0, 1'bz});
endtask

// Compares the first num_bytes received bytes with the prediction
task automatic compare_packet(input int num_bytes, input string label);
    for (int i = 0; i < num_bytes; i++) begin
        check_value($sformatf("%s byte %0d", label, i), {24'b0, rx_buf[i]},
                    {24'b0, exp_buf[i]});
    end
endtask

// ------------------------------
// Stimulus and SPI master
// ------------------------------

// New sensor values land on a falling clk edge like every other input
task automatic set_inputs(
    input imu_spi_pkg::imu_quat_t  q,
    input imu_spi_pkg::imu_gyro_t  g,
    input imu_spi_pkg::imu_flags_t f
);
    @(negedge clk);
    quat  = q;
    gyro  = g;
    flags = f;
endtask

// Mode 0 master, sck idles low and sdo is taken just as sck rises
// Each sck half period is 2 clk, so one byte costs 32 clk
task automatic spi_read(input int num_bytes);
    imu_spi_pkg::pkt_byte_t rx;
    // cs_n stays high long enough for the slow flag path to reach the snapshot
    repeat (IDLE_CYCLES) @(negedge clk);
    expect_sdo_released("between transactions");
    cs_n = 1'b0;
    repeat (2) @(negedge clk);
    for (int n = 0; n < num_bytes; n++) begin
        rx = '0;
        for (int b = 0; b < 8; b++) begin
            // sdo last moved at the previous falling sck, two clk ago
            rx  = {rx[6:0], sdo};
            sck = 1'b1;
            repeat (2) @(negedge clk);
            sck = 1'b0;
            repeat (2) @(negedge clk);
        end
        rx_buf[n] = rx;
    end
    cs_n = 1'b1;
endtask

// ------------------------------
// Prediction
// ------------------------------

// Header, then each axis high byte first, then the flags nibble
// Everything past byte 15 is padding
task automatic predict_packet(
    input imu_spi_pkg::imu_quat_t  q,
    input imu_spi_pkg::imu_gyro_t  g,
    input imu_spi_pkg::imu_flags_t f
);
    for (int i = 0; i < 32; i++) begin
        exp_buf[i] = 8'h00;
    end
    exp_buf[0]  = `IMU_PKT_HEADER;
    exp_buf[1]  = q.w[15:8];
    exp_buf[2]  = q.w[7:0];
    exp_buf[3]  = q.x[15:8];
    exp_buf[4]  = q.x[7:0];
    exp_buf[5]  = q.y[15:8];
    exp_buf[6]  = q.y[7:0];
    exp_buf[7]  = q.z[15:8];
    exp_buf[8]  = q.z[7:0];
    exp_buf[9]  = g.x[15:8];
    exp_buf[10] = g.x[7:0];
    exp_buf[11] = g.y[15:8];
    exp_buf[12] = g.y[7:0];
    exp_buf[13] = g.z[15:8];
    exp_buf[14] = g.z[7:0];
    // Bit 0 quat valid, bit 1 gyro valid, bit 2 initialized, bit 3 error
    exp_buf[`IMU_PKT_BYTES-1] = {4'h0, f.error, f.initialized, f.gyro_valid, f.quat_valid};
endtask

`endif

/* verif/imu_spi_tb.sv */
`default_nettype none

`include "imu_spi_params.svh"

module imu_spi_tb;

    // ------------------------------
    // Run limits
    // ------------------------------

    // 16 transactions move 249 bytes at 32 clk each, plus about 12 clk
    // of setup per transaction, which comes to roughly 8200 clk
    localparam int TIMEOUT_CYCLES = 12000;

    // The valid flags need 4 clk edges, so cs_n stays high this long before each read
    localparam int IDLE_CYCLES = 8;

    logic clk;
    logic cs_n;
    logic sck;
    wire  sdo;
    imu_spi_pkg::imu_quat_t  quat;
    imu_spi_pkg::imu_gyro_t  gyro;
    imu_spi_pkg::imu_flags_t flags;

    // What the master model received and what the packet rule predicts
    imu_spi_pkg::pkt_byte_t rx_buf  [0:31];
    imu_spi_pkg::pkt_byte_t exp_buf [0:31];

    logic [31:0] rng_state;
    int          cycle_count = 0;

    imu_spi_top dut_i (
        .clk   (clk),
        .cs_n  (cs_n),
        .sck   (sck),
        .quat  (quat),
        .gyro  (gyro),
        .flags (flags),
        .sdo   (sdo)
    );

    `include "imu_spi_tb_tasks.svh"

    // ------------------------------
    // Clock and timeout
    // ------------------------------

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d clk cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------
    // Directed tests
    // ------------------------------

    // MISO floats once the reset hold is over
    task automatic idle_after_reset();
        @(negedge clk);
        expect_sdo_released("after reset");
    endtask

    // Known values with a mix of signs and all flags set
    task automatic read_basic_packet();
        imu_spi_pkg::imu_quat_t q;
        imu_spi_pkg::imu_gyro_t g;
        q.w = 16'h1234;
        q.x = 16'hABCD;
        q.y = 16'h8001;
        q.z = 16'h7FFF;
        g.x = 16'hFF00;
        g.y = 16'h0102;
        g.z = 16'hC3A5;
        set_inputs(q, g, 4'hF);
        spi_read(16);
        predict_packet(q, g, 4'hF);
        compare_packet(16, "basic");
        // A few bytes are also compared with literal values that do not come from the prediction
        check_value("basic header", {24'b0, rx_buf[0]}, 32'hAA);
        check_value("basic quat w msb", {24'b0, rx_buf[1]}, 32'h12);
        check_value("basic quat x lsb", {24'b0, rx_buf[4]}, 32'hCD);
        check_value("basic flags", {24'b0, rx_buf[15]}, 32'h0F);
    endtask

    // Setting one flag at a time makes a swapped bit show up in the last byte
    task automatic walk_flag_bits();
        imu_spi_pkg::imu_flags_t f;
        for (int k = 0; k < 4; k++) begin
            f = imu_spi_pkg::imu_flags_t'(4'b0001 << k);
            set_inputs(quat, gyro, f);
            spi_read(16);
            predict_packet(quat, gyro, f);
            compare_packet(16, $sformatf("flag %0d", k));
            check_value("flags byte", {24'b0, rx_buf[15]}, 32'h1 << k);
        end
    endtask

    // Inputs change during the read, which must still see the old sample
    task automatic freeze_during_read();
        imu_spi_pkg::imu_quat_t q_old;
        imu_spi_pkg::imu_gyro_t g_old;
        imu_spi_pkg::imu_quat_t q_new;
        imu_spi_pkg::imu_gyro_t g_new;
        q_old = {16'h0A0B, 16'h0C0D, 16'h0E0F, 16'h1011};
        g_old = {16'h2122, 16'h2324, 16'h2526};
        q_new = {16'hF0E1, 16'hD2C3, 16'hB4A5, 16'h9687};
        g_new = {16'h7869, 16'h5A4B, 16'h3C2D};
        set_inputs(q_old, g_old, 4'b0101);
        fork
            spi_read(16);
            begin
                // Lands around byte 2 of the transaction
                repeat (100) @(negedge clk);
                set_inputs(q_new, g_new, 4'b1010);
            end
        join
        predict_packet(q_old, g_old, 4'b0101);
        compare_packet(16, "frozen");
        spi_read(16);
        predict_packet(q_new, g_new, 4'b1010);
        compare_packet(16, "after freeze");
    endtask

    // Reading past the end gives zeros and raising cs_n early restarts the packet
    task automatic overrun_and_abort();
        imu_spi_pkg::imu_quat_t q;
        imu_spi_pkg::imu_gyro_t g;
        q = {16'h4455, 16'h6677, 16'h8899, 16'hAABB};
        g = {16'hCCDD, 16'hEEFF, 16'h0011};
        set_inputs(q, g, 4'b0011);
        spi_read(20);
        predict_packet(q, g, 4'b0011);
        compare_packet(20, "overrun");
        spi_read(5);
        compare_packet(5, "aborted");
        spi_read(16);
        compare_packet(16, "after abort");
    endtask

    // Pseudo-random axes and flags from the xorshift sequence
    task automatic read_random_samples();
        imu_spi_pkg::imu_quat_t  q;
        imu_spi_pkg::imu_gyro_t  g;
        imu_spi_pkg::imu_flags_t f;
        for (int r = 0; r < 6; r++) begin
            rng_state = xorshift32(rng_state);
            q.w = rng_state[15:0];
            q.x = rng_state[31:16];
            rng_state = xorshift32(rng_state);
            q.y = rng_state[15:0];
            q.z = rng_state[31:16];
            rng_state = xorshift32(rng_state);
            g.x = rng_state[15:0];
            g.y = rng_state[31:16];
            rng_state = xorshift32(rng_state);
            g.z = rng_state[15:0];
            f   = rng_state[19:16];
            set_inputs(q, g, f);
            spi_read(16);
            predict_packet(q, g, f);
            compare_packet(16, $sformatf("random %0d", r));
        end
    endtask

    // ------------------------------
    // Sequence
    // ------------------------------

    initial begin
        cs_n      = 1'b1;
        sck       = 1'b0;
        quat      = '0;
        gyro      = '0;
        flags     = '0;
        rng_state = 32'd72751;
        // cs_n high resets the sck side while the clk side fills with zeros
        repeat (8) @(negedge clk);
        idle_after_reset();
        read_basic_packet();
        walk_flag_bits();
        freeze_during_read();
        overrun_and_abort();
        read_random_samples();
        @(negedge clk);
        expect_sdo_released("at the end");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/imu_sample_capture.sv */
`default_nettype none

`include "imu_spi_params.svh"

module imu_sample_capture (
    input  logic                     clk,
    input  logic                     cs_n,
    input  imu_spi_pkg::imu_quat_t   quat,
    input  imu_spi_pkg::imu_gyro_t   gyro,
    input  imu_spi_pkg::imu_flags_t  flags,
    output imu_spi_pkg::imu_sample_t snapshot
);

    // ------------------------------
    // Input registers
    // ------------------------------

    // Every sensor input is registered once so that the snapshot never
    // samples a value that is still settling from the controller logic
    imu_spi_pkg::imu_quat_t  quat_q;
    imu_spi_pkg::imu_gyro_t  gyro_q;
    imu_spi_pkg::imu_flags_t flags_q;

    // These load every cycle and hold valid data a couple of edges after
    // the clock starts running
    always_ff @(posedge clk) begin
        quat_q  <= quat;
        gyro_q  <= gyro;
        flags_q <= flags;
    end

    // ------------------------------
    // Valid-flag synchronizers
    // ------------------------------

    // Bit 1 of each stage carries gyro_valid, bit 0 carries quat_valid
    // Stage 0 is the first flop of the chain, the last stage feeds the snapshot
    logic [`IMU_SYNC_STAGES-1:0][1:0] valid_sync_q;

    always_ff @(posedge clk) begin
        valid_sync_q[0] <= {flags_q.gyro_valid, flags_q.quat_valid};
        // Remaining stages just pass the pair along
        for (int i = 1; i < `IMU_SYNC_STAGES; i++) begin
            valid_sync_q[i] <= valid_sync_q[i-1];
        end
    end

    // Synchronized valid flags as seen at the end of the chain
    logic quat_valid_sync;
    logic gyro_valid_sync;

    assign quat_valid_sync = valid_sync_q[`IMU_SYNC_STAGES-1][0];
    assign gyro_valid_sync = valid_sync_q[`IMU_SYNC_STAGES-1][1];

    // ------------------------------
    // Chip-select gated snapshot
    // ------------------------------

    // The snapshot tracks the registered inputs while the bus is idle
    // Once cs_n drops it holds, so the serializer sees one consistent
    // sample for the whole transaction without any handshake
    // The master keeps cs_n high long enough for the flag path to settle
    always_ff @(posedge clk) begin
        if (cs_n) begin
            snapshot.quat              <= quat_q;
            snapshot.gyro              <= gyro_q;
            snapshot.flags.quat_valid  <= quat_valid_sync;
            snapshot.flags.gyro_valid  <= gyro_valid_sync;
            // initialized and error are slow status levels, one register is enough
            snapshot.flags.initialized <= flags_q.initialized;
            snapshot.flags.error       <= flags_q.error;
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------

    // While a transaction is running in the sck domain the sample it reads
    // must not move underneath it
    // Both edges are required low since cs_n is asynchronous to clk
    a_snapshot_frozen : assert property (
        @(posedge clk) (!cs_n && !$past(cs_n)) |-> $stable(snapshot)
    ) else $error("snapshot changed while cs_n was held low");

endmodule

`default_nettype wire

/* verilog/imu_spi_params.svh */
`ifndef IMU_SPI_PARAMS_SVH
`define IMU_SPI_PARAMS_SVH

// ------------------------------
// Packet layout
// ------------------------------

// Number of bytes in one telemetry packet, header and flags included
`define IMU_PKT_BYTES 16

// First byte of every packet, lets the MCU find the frame start
`define IMU_PKT_HEADER 8'hAA

// ------------------------------
// Clock domain crossing
// ------------------------------

// Flip-flops in each valid-flag synchronizer chain
`define IMU_SYNC_STAGES 2

`endif

/* verilog/imu_spi_pkg.sv */
`default_nettype none

package imu_spi_pkg;

    // ------------------------------
    // Sensor values
    // ------------------------------

    // One signed axis reading as the sensor controller delivers it
    typedef logic signed [15:0] imu_axis_t;

    // Quaternion, w is declared first so it lands in the upper bits
    // Concatenating the struct therefore gives the packet byte order directly
    typedef struct packed {
        imu_axis_t w;
        imu_axis_t x;
        imu_axis_t y;
        imu_axis_t z;
    } imu_quat_t;

    // Angular rate, same ordering rule as the quaternion
    typedef struct packed {
        imu_axis_t x;
        imu_axis_t y;
        imu_axis_t z;
    } imu_gyro_t;

    // Status bits, quat_valid sits in bit 0 so the struct maps onto
    // the low nibble of the flags byte without any reordering
    typedef struct packed {
        logic error;
        logic initialized;
        logic gyro_valid;
        logic quat_valid;
    } imu_flags_t;

    // Frozen copy of everything the packet carries except the header
    // This is the only bundle that crosses from clk into the sck domain
    typedef struct packed {
        imu_quat_t  quat;
        imu_gyro_t  gyro;
        imu_flags_t flags;
    } imu_sample_t;

    // ------------------------------
    // Packet framing
    // ------------------------------

    // One byte on the wire
    typedef logic [7:0] pkt_byte_t;

    // Byte position in a transaction
    // One value beyond the last byte means the master has read past the end
    typedef logic [4:0] pkt_idx_t;

    // Bit position inside the byte being shifted
    typedef logic [2:0] bit_idx_t;

endpackage

`default_nettype wire

/* verilog/imu_spi_top.sv */
`default_nettype none

module imu_spi_top (
    input  logic                    clk,
    input  logic                    cs_n,
    input  logic                    sck,
    input  imu_spi_pkg::imu_quat_t  quat,
    input  imu_spi_pkg::imu_gyro_t  gyro,
    input  imu_spi_pkg::imu_flags_t flags,
    output logic                    sdo
);

    // ------------------------------
    // Domain crossing
    // ------------------------------

    // Sample frozen in the clk domain and read in the sck domain
    // It is quasi-static while cs_n is low, so no further sync is needed
    imu_spi_pkg::imu_sample_t snapshot;

    // Registers the sensor inputs and holds them for the transaction
    imu_sample_capture u_capture (
        .clk      (clk),
        .cs_n     (cs_n),
        .quat     (quat),
        .gyro     (gyro),
        .flags    (flags),
        .snapshot (snapshot)
    );

    // ------------------------------
    // SPI slave
    // ------------------------------

    // Shifts the packet out on MISO, clocked only by the master's sck
    // MOSI is not used since the port is read-only
    spi_packet_tx u_tx (
        .sck      (sck),
        .cs_n     (cs_n),
        .snapshot (snapshot),
        .sdo      (sdo)
    );

endmodule

`default_nettype wire

/* verilog/spi_packet_tx.sv */
`default_nettype none

`include "imu_spi_params.svh"

module spi_packet_tx (
    input  logic                     sck,
    input  logic                     cs_n,
    input  imu_spi_pkg::imu_sample_t snapshot,
    output logic                     sdo
);

    // ------------------------------
    // Packet assembly
    // ------------------------------

    // Whole packet as a byte array, index 15 holds byte 0 (the header)
    // The sensor structs are already big-endian in declaration order,
    // so plain concatenation produces MSB-first axis bytes
    // Upper nibble of the flags byte is padded with zeros
    imu_spi_pkg::pkt_byte_t [`IMU_PKT_BYTES-1:0] pkt_bytes;

    assign pkt_bytes = {
        `IMU_PKT_HEADER,
        snapshot.quat,
        snapshot.gyro,
        4'h0,
        snapshot.flags
    };

    // ------------------------------
    // Shift state
    // ------------------------------

    // Byte currently sitting in the shift register
    imu_spi_pkg::pkt_byte_t shift_q;

    // Index of that byte within the transaction, saturates past the end
    imu_spi_pkg::pkt_idx_t  byte_idx;

    // Number of bits of the current byte already moved out of the MSB
    imu_spi_pkg::bit_idx_t  bit_idx;

    // Set once the master has sampled the first bit
    // Until then a falling sck must not advance, otherwise bit 7 of the
    // header would be lost before anyone read it
    logic first_edge;

    // Next byte index and the byte that belongs there
    imu_spi_pkg::pkt_idx_t  next_idx;
    imu_spi_pkg::pkt_byte_t next_byte;

    // ------------------------------
    // Next byte selection
    // ------------------------------

    always_comb begin
        // Stop counting at the packet length, every later byte is padding
        if (byte_idx == `IMU_PKT_BYTES) begin
            next_idx = byte_idx;
        end else begin
            next_idx = byte_idx + 5'd1;
        end

        // Reads past the last packet byte return zeros
        if (next_idx < `IMU_PKT_BYTES) begin
            next_byte = pkt_bytes[`IMU_PKT_BYTES - 1 - next_idx];
        end else begin
            next_byte = '0;
        end
    end

    // ------------------------------
    // First rising edge tracking
    // ------------------------------

    // Mode 0 has the master sample on rising sck
    // The slave may only change data on falling edges after that first sample
    always_ff @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            first_edge <= 1'b0;
        end else begin
            first_edge <= 1'b1;
        end
    end

    // ------------------------------
    // Serializer
    // ------------------------------

    // cs_n high holds everything in reset with the header preloaded,
    // so bit 7 of the header is on sdo the moment cs_n falls
    always_ff @(negedge sck or posedge cs_n) begin
        if (cs_n) begin
            shift_q  <= `IMU_PKT_HEADER;
            byte_idx <= '0;
            bit_idx  <= '0;
        end else if (first_edge) begin
            if (bit_idx == 3'd7) begin
                // Last bit of this byte has been sampled, bring in the next one
                shift_q  <= next_byte;
                byte_idx <= next_idx;
                bit_idx  <= '0;
            end else begin
                // MSB first, the next bit moves up into position 7
                shift_q <= {shift_q[6:0], 1'b0};
                bit_idx <= bit_idx + 3'd1;
            end
        end
    end

    // ------------------------------
    // Output driver
    // ------------------------------

    // The MISO line is shared with other slaves on the MCU side,
    // so it is released whenever this device is not selected
    assign sdo = cs_n ? 1'bz : shift_q[7];

    // ------------------------------
    // Assertions
    // ------------------------------

    // The index may sit at the packet length for overrun reads but never beyond
    a_byte_idx_bound : assert property (
        @(posedge sck) disable iff (cs_n) byte_idx <= `IMU_PKT_BYTES
    ) else $error("byte index ran past the packet length");

    // A new byte must start at bit 0, or the MCU would see misaligned bytes
    // Checked one falling edge after the index moved
    a_byte_aligned : assert property (
        @(negedge sck) disable iff (cs_n) $changed(byte_idx) |-> (bit_idx == '0)
    ) else $error("new byte loaded with a nonzero bit index");

endmodule

`default_nettype wire
